//--- list.f
hdl/host_cfg_pkg.sv
hdl/host_bus_pkg.sv
hdl/req_credit_buffer.sv
hdl/host_addr_router.sv
hdl/l2_bank_array.sv
hdl/cfg_regs.sv
hdl/dma_evt_rx.sv
hdl/host_domain.sv
tests/tb_host_domain.sv

//--- run.sh
#!/usr/bin/env bash
# Build the host domain testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f list.f \
  --top-module tb_host_domain -o tb_host_domain \
  || { echo "Build failed"; exit 1; }

./obj_dir/tb_host_domain | tee /dev/stderr | grep -qx "Everything OK" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- tests/tb_host_domain.sv
// Host domain testbench
// Table-driven requests through the credit port, checked against a model
// of L2 and the configuration registers, plus cluster DMA event handshakes
`timescale 1ns/100ps

module tb_host_domain;

  localparam int unsigned NbL2Banks     = host_cfg_pkg::DefNbL2Banks;
  localparam int unsigned L2BankWords   = host_cfg_pkg::DefL2BankWords;
  localparam int unsigned BufferDepth   = host_cfg_pkg::DefBufferDepth;
  localparam int unsigned TotalWords    = NbL2Banks * L2BankWords;
  localparam logic [31:0] L2Bytes       = 32'(TotalWords * 4);
  localparam int          NumEntries    = 70;
  localparam int          NumDmaEvents  = 3;
  localparam int          TimeoutCycles = 20 * NumEntries + 200;

  typedef struct packed {
    host_bus_pkg::host_req_t req;
    host_bus_pkg::host_rsp_t exp;
  } entry_t;

  logic                    clk_i = 1'b0;
  logic                    arst_n_i;
  logic                    req_valid_i;
  host_bus_pkg::host_req_t req_i;
  logic                    credit_o;
  logic                    rsp_valid_o;
  host_bus_pkg::host_rsp_t rsp_o;
  logic                    dma_evt_valid_i;
  logic                    dma_evt_ack_o;

  entry_t                  stim_table [NumEntries];
  host_bus_pkg::host_rsp_t exp_q [$];
  host_bus_pkg::data_t     l2_model [TotalWords];
  host_bus_pkg::data_t     cfg_model [host_cfg_pkg::CfgNumRegs];
  int                      n_entries = 0;
  int                      credits = BufferDepth;
  int                      cycles = 0;
  int                      errors = 0;
  int                      seed = 32'h2e06_a492;

  host_domain #(
    .NbL2Banks   ( NbL2Banks   ),
    .L2BankWords ( L2BankWords ),
    .BufferDepth ( BufferDepth )
  ) host_domain_inst (
    .clk_i           ( clk_i           ),
    .arst_n_i        ( arst_n_i        ),
    .req_valid_i     ( req_valid_i     ),
    .req_i           ( req_i           ),
    .credit_o        ( credit_o        ),
    .rsp_valid_o     ( rsp_valid_o     ),
    .rsp_o           ( rsp_o           ),
    .dma_evt_valid_i ( dma_evt_valid_i ),
    .dma_evt_ack_o   ( dma_evt_ack_o   )
  );

  always #4 clk_i = ~clk_i;

  task automatic stop_with_failure();
    errors++;
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_rsp(input string name, input host_bus_pkg::host_rsp_t got,
                           input host_bus_pkg::host_rsp_t exp);
    if (got !== exp) begin
      $display("ERR %s: rdata %h err %h, expected rdata %h err %h",
               name, got.rdata, got.err, exp.rdata, exp.err);
      stop_with_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s: got %h, expected %h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("ERR %s: got %h, expected %h", name, got, exp);
      stop_with_failure();
    end
  endtask

  // Expected response from the memory map rules with the model updated on writes
  task automatic add_entry(input logic we, input host_bus_pkg::addr_t addr,
                           input host_bus_pkg::data_t wdata);
    host_bus_pkg::host_rsp_t exp_rsp;
    int unsigned             idx;
    exp_rsp = '0;
    if (addr >= host_cfg_pkg::L2BaseAddr && addr < host_cfg_pkg::L2BaseAddr + L2Bytes) begin
      idx = (addr - host_cfg_pkg::L2BaseAddr) >> 2;
      if (we) begin
        l2_model[idx] = wdata;
        exp_rsp.rdata = wdata;
      end else begin
        exp_rsp.rdata = l2_model[idx];
      end
    end else if (addr >= host_cfg_pkg::CfgBaseAddr &&
                 addr < host_cfg_pkg::CfgBaseAddr + 32'(host_cfg_pkg::CfgNumRegs * 4)) begin
      idx = (addr - host_cfg_pkg::CfgBaseAddr) >> 2;
      if (we && (addr - host_cfg_pkg::CfgBaseAddr) == host_cfg_pkg::CfgDmaEvtCntOff) begin
        exp_rsp.err = 1'b1;
      end else if (we) begin
        cfg_model[idx] = wdata;
      end else begin
        exp_rsp.rdata = cfg_model[idx];
      end
    end else begin
      exp_rsp.err = 1'b1;
    end
    if (n_entries >= NumEntries) begin
      $display("Stimulus table is too small for the requested entries");
      stop_with_failure();
    end
    stim_table[n_entries].req.we    = we;
    stim_table[n_entries].req.addr  = addr;
    stim_table[n_entries].req.wdata = wdata;
    stim_table[n_entries].exp       = exp_rsp;
    n_entries++;
  endtask

  // Back to back issue held off only by the credit model
  task automatic run_entries(input int first, input int last);
    for (int i = first; i < last; i++) begin
      @(negedge clk_i);
      while (credits == 0) begin
        req_valid_i = 1'b0;
        @(negedge clk_i);
      end
      req_valid_i = 1'b1;
      req_i       = stim_table[i].req;
      credits--;
      exp_q.push_back(stim_table[i].exp);
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);
    check_count("credits", credits, BufferDepth);
  endtask

  task automatic dma_handshake();
    @(negedge clk_i);
    dma_evt_valid_i = 1'b1;
    while (!dma_evt_ack_o) begin
      @(negedge clk_i);
    end
    dma_evt_valid_i = 1'b0;
    while (dma_evt_ack_o) begin
      @(negedge clk_i);
    end
  endtask

  // Outputs sampled mid-cycle
  always @(negedge clk_i) begin
    if (arst_n_i) begin
      if (credit_o) begin
        credits++;
      end
      if (rsp_valid_o) begin
        if (exp_q.size() == 0) begin
          $display("A response arrived with no request outstanding");
          stop_with_failure();
        end else begin
          check_rsp("rsp_o", rsp_o, exp_q.pop_front());
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout: the test did not complete within %0d cycles", TimeoutCycles);
      stop_with_failure();
    end
  end

  initial begin
    int seg2_first;
    arst_n_i        = 1'b0;
    req_valid_i     = 1'b0;
    req_i           = '0;
    dma_evt_valid_i = 1'b0;
    for (int k = 0; k < TotalWords; k++) begin
      l2_model[k] = '0;
    end
    for (int k = 0; k < host_cfg_pkg::CfgNumRegs; k++) begin
      cfg_model[k] = '0;
    end
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    check_bit("credit_o", credit_o, 1'b0);
    check_bit("rsp_valid_o", rsp_valid_o, 1'b0);
    check_bit("dma_evt_ack_o", dma_evt_ack_o, 1'b0);

    // Registers after reset
    for (int k = 0; k < host_cfg_pkg::CfgNumRegs; k++) begin
      add_entry(1'b0, host_cfg_pkg::CfgBaseAddr + 32'(4 * k), '0);
    end
    // Two rows across every bank, then the top of the array
    for (int k = 0; k < 2 * NbL2Banks; k++) begin
      add_entry(1'b1, host_cfg_pkg::L2BaseAddr + 32'(4 * k), $random(seed));
    end
    for (int k = 0; k < 8; k++) begin
      add_entry(1'b1, host_cfg_pkg::L2BaseAddr + 32'(4 * (TotalWords - 8 + k)), $random(seed));
    end
    for (int k = 0; k < 2 * NbL2Banks; k++) begin
      add_entry(1'b0, host_cfg_pkg::L2BaseAddr + 32'(4 * k), '0);
    end
    for (int k = 0; k < 8; k++) begin
      add_entry(1'b0, host_cfg_pkg::L2BaseAddr + 32'(4 * (TotalWords - 8 + k)), '0);
    end
    // Window registers
    add_entry(1'b1, host_cfg_pkg::CfgBaseAddr + host_cfg_pkg::CfgCacheStartOff, $random(seed));
    add_entry(1'b1, host_cfg_pkg::CfgBaseAddr + host_cfg_pkg::CfgCacheEndOff, $random(seed));
    add_entry(1'b1, host_cfg_pkg::CfgBaseAddr + host_cfg_pkg::CfgSpmStartOff, $random(seed));
    add_entry(1'b0, host_cfg_pkg::CfgBaseAddr + host_cfg_pkg::CfgCacheStartOff, '0);
    add_entry(1'b0, host_cfg_pkg::CfgBaseAddr + host_cfg_pkg::CfgCacheEndOff, '0);
    add_entry(1'b0, host_cfg_pkg::CfgBaseAddr + host_cfg_pkg::CfgSpmStartOff, '0);
    add_entry(1'b1, host_cfg_pkg::CfgBaseAddr + host_cfg_pkg::CfgDmaEvtCntOff, $random(seed));
    add_entry(1'b0, host_cfg_pkg::CfgBaseAddr + host_cfg_pkg::CfgDmaEvtCntOff, '0);
    // Unmapped addresses just outside each window and far away
    add_entry(1'b0, 32'h0000_1000, '0);
    add_entry(1'b1, host_cfg_pkg::L2BaseAddr + L2Bytes, $random(seed));
    add_entry(1'b1, host_cfg_pkg::CfgBaseAddr + 32'h10, $random(seed));
    add_entry(1'b0, host_cfg_pkg::CfgBaseAddr - 32'h4, '0);
    add_entry(1'b0, host_cfg_pkg::L2BaseAddr, '0);
    add_entry(1'b0, host_cfg_pkg::L2BaseAddr + 32'(4 * (TotalWords - 1)), '0);
    add_entry(1'b0, host_cfg_pkg::CfgBaseAddr, '0);
    run_entries(0, n_entries);

    repeat (NumDmaEvents) dma_handshake();
    cfg_model[host_cfg_pkg::CfgDmaEvtCntOff >> 2] = NumDmaEvents;
    seg2_first = n_entries;
    add_entry(1'b0, host_cfg_pkg::CfgBaseAddr + host_cfg_pkg::CfgDmaEvtCntOff, '0);
    add_entry(1'b1, host_cfg_pkg::CfgBaseAddr + host_cfg_pkg::CfgDmaEvtCntOff, $random(seed));
    add_entry(1'b0, host_cfg_pkg::CfgBaseAddr + host_cfg_pkg::CfgDmaEvtCntOff, '0);
    run_entries(seg2_first, n_entries);

    if (errors == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      stop_with_failure();
    end
  end

endmodule

//--- hdl/host_domain.sv
// Host domain memory side
// Credit-controlled host request port in front of a banked L2 scratchpad
// and the configuration registers, plus the cluster DMA event receiver
`timescale 1ns/100ps

module host_domain #(
  parameter int unsigned NbL2Banks   = host_cfg_pkg::DefNbL2Banks,
  parameter int unsigned L2BankWords = host_cfg_pkg::DefL2BankWords,
  parameter int unsigned BufferDepth = host_cfg_pkg::DefBufferDepth
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    req_valid_i,
  input  host_bus_pkg::host_req_t req_i,
  output logic                    credit_o,
  output logic                    rsp_valid_o,
  output host_bus_pkg::host_rsp_t rsp_o,
  input  logic                    dma_evt_valid_i,
  output logic                    dma_evt_ack_o
);

  logic                    fwd_valid;
  host_bus_pkg::host_req_t fwd_req;
  logic                    l2_valid;
  host_bus_pkg::tgt_req_t  l2_req;
  host_bus_pkg::data_t     l2_rdata;
  logic                    cfg_valid;
  host_bus_pkg::tgt_req_t  cfg_req;
  host_bus_pkg::host_rsp_t cfg_rsp;
  logic                    dma_evt;

  req_credit_buffer #(
    .Depth ( BufferDepth )
  ) req_credit_buffer_inst (
    .clk_i      ( clk_i       ),
    .arst_n_i   ( arst_n_i    ),
    .push_i     ( req_valid_i ),
    .push_req_i ( req_i       ),
    .pop_o      ( fwd_valid   ),
    .pop_req_o  ( fwd_req     ),
    .credit_o   ( credit_o    )
  );

  host_addr_router #(
    .NbL2Banks   ( NbL2Banks   ),
    .L2BankWords ( L2BankWords )
  ) host_addr_router_inst (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .valid_i     ( fwd_valid   ),
    .req_i       ( fwd_req     ),
    .l2_valid_o  ( l2_valid    ),
    .l2_req_o    ( l2_req      ),
    .l2_rdata_i  ( l2_rdata    ),
    .cfg_valid_o ( cfg_valid   ),
    .cfg_req_o   ( cfg_req     ),
    .cfg_rsp_i   ( cfg_rsp     ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_o       ( rsp_o       )
  );

  l2_bank_array #(
    .NbL2Banks   ( NbL2Banks   ),
    .L2BankWords ( L2BankWords )
  ) l2_bank_array_inst (
    .clk_i    ( clk_i    ),
    .arst_n_i ( arst_n_i ),
    .valid_i  ( l2_valid ),
    .req_i    ( l2_req   ),
    .rdata_o  ( l2_rdata )
  );

  cfg_regs cfg_regs_inst (
    .clk_i     ( clk_i     ),
    .arst_n_i  ( arst_n_i  ),
    .valid_i   ( cfg_valid ),
    .req_i     ( cfg_req   ),
    .dma_evt_i ( dma_evt   ),
    .rsp_o     ( cfg_rsp   )
  );

  dma_evt_rx dma_evt_rx_inst (
    .clk_i    ( clk_i           ),
    .arst_n_i ( arst_n_i        ),
    .valid_i  ( dma_evt_valid_i ),
    .ack_o    ( dma_evt_ack_o   ),
    .evt_o    ( dma_evt         )
  );

endmodule

//--- hdl/dma_evt_rx.sv
// Cluster DMA event receiver
// Two-flop synchronizer on the incoming valid level; the synchronized
// level acknowledges, and its rising edge becomes a one-cycle event pulse
`timescale 1ns/100ps

module dma_evt_rx (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic valid_i,
  output logic ack_o,
  output logic evt_o
);

  logic [1:0] sync_q;
  logic       level_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q  <= '0;
      level_q <= 1'b0;
    end else begin
      sync_q  <= {sync_q[0], valid_i};
      level_q <= sync_q[1];
    end
  end

  assign ack_o = sync_q[1];
  // Rising edge of the synchronized valid
  assign evt_o = sync_q[1] && !level_q;

endmodule

//--- hdl/cfg_regs.sv
// Host configuration registers
// Cache window registers (cached start, cached end, scratchpad start) and
// a read-only counter of cluster DMA events
`timescale 1ns/100ps

module cfg_regs (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    valid_i,
  input  host_bus_pkg::tgt_req_t  req_i,
  input  logic                    dma_evt_i,
  output host_bus_pkg::host_rsp_t rsp_o
);

  logic [31:0]             cache_start_q;
  logic [31:0]             cache_end_q;
  logic [31:0]             spm_start_q;
  logic [31:0]             evt_cnt_q;
  logic [31:0]             off;
  host_bus_pkg::host_rsp_t rsp_q;

  assign off = {req_i.idx[29:0], 2'b00};

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cache_start_q <= '0;
      cache_end_q   <= '0;
      spm_start_q   <= '0;
      evt_cnt_q     <= '0;
      rsp_q         <= '0;
    end else begin
      if (dma_evt_i) begin
        evt_cnt_q <= evt_cnt_q + 32'd1;
      end
      if (valid_i) begin
        rsp_q <= '0;
        case (off)
          host_cfg_pkg::CfgCacheStartOff: begin
            if (req_i.we) cache_start_q <= req_i.wdata;
            else rsp_q.rdata <= cache_start_q;
          end
          host_cfg_pkg::CfgCacheEndOff: begin
            if (req_i.we) cache_end_q <= req_i.wdata;
            else rsp_q.rdata <= cache_end_q;
          end
          host_cfg_pkg::CfgSpmStartOff: begin
            if (req_i.we) spm_start_q <= req_i.wdata;
            else rsp_q.rdata <= spm_start_q;
          end
          // Counter is read-only
          host_cfg_pkg::CfgDmaEvtCntOff: begin
            if (req_i.we) rsp_q.err <= 1'b1;
            else rsp_q.rdata <= evt_cnt_q;
          end
          default: rsp_q.err <= 1'b1;
        endcase
      end
    end
  end

  assign rsp_o = rsp_q;

endmodule

//--- hdl/l2_bank_array.sv
// L2 scratchpad banks
// Word-interleaved banks: the low word index bits pick the bank and the
// upper bits the row. Every access completes in one cycle, a write
// returns the word it stored.
`timescale 1ns/100ps

module l2_bank_array #(
  parameter int unsigned NbL2Banks   = 8,
  parameter int unsigned L2BankWords = 256
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   valid_i,
  input  host_bus_pkg::tgt_req_t req_i,
  output host_bus_pkg::data_t    rdata_o
);

  localparam int unsigned BankW = $clog2(NbL2Banks);
  localparam int unsigned RowW  = $clog2(L2BankWords);

  host_bus_pkg::data_t mem_q [NbL2Banks][L2BankWords];
  host_bus_pkg::data_t rdata_q;

  logic [BankW-1:0] bank;
  logic [RowW-1:0]  row;

  assign bank = req_i.idx[BankW-1:0];
  assign row  = req_i.idx[BankW +: RowW];

  // Storage
  always_ff @(posedge clk_i) begin
    if (valid_i && req_i.we) begin
      mem_q[bank][row] <= req_i.wdata;
    end
  end

  // Read port that echoes the write data
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rdata_q <= '0;
    end else if (valid_i) begin
      if (req_i.we) begin
        rdata_q <= req_i.wdata;
      end else begin
        rdata_q <= mem_q[bank][row];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- hdl/host_addr_router.sv
// Host address router
// Steers each request to the L2 banks or the register block and returns
// the matching response one cycle later. Unmapped requests get an error.
`timescale 1ns/100ps

module host_addr_router #(
  parameter int unsigned NbL2Banks   = 8,
  parameter int unsigned L2BankWords = 256
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    valid_i,
  input  host_bus_pkg::host_req_t req_i,
  output logic                    l2_valid_o,
  output host_bus_pkg::tgt_req_t  l2_req_o,
  input  host_bus_pkg::data_t     l2_rdata_i,
  output logic                    cfg_valid_o,
  output host_bus_pkg::tgt_req_t  cfg_req_o,
  input  host_bus_pkg::host_rsp_t cfg_rsp_i,
  output logic                    rsp_valid_o,
  output host_bus_pkg::host_rsp_t rsp_o
);

  localparam logic [31:0] L2Bytes  = 32'(NbL2Banks * L2BankWords * 4);
  localparam logic [31:0] CfgBytes = 32'(host_cfg_pkg::CfgNumRegs * 4);

  host_bus_pkg::addr_t l2_off;
  host_bus_pkg::addr_t cfg_off;
  logic                hit_l2;
  logic                hit_cfg;
  logic                valid_q;
  logic                sel_l2_q;
  logic                sel_cfg_q;

  // Below-base addresses wrap to large offsets and miss
  assign l2_off  = req_i.addr - host_cfg_pkg::L2BaseAddr;
  assign cfg_off = req_i.addr - host_cfg_pkg::CfgBaseAddr;
  assign hit_l2  = (l2_off < L2Bytes);
  assign hit_cfg = (cfg_off < CfgBytes);

  assign l2_valid_o     = valid_i && hit_l2;
  assign l2_req_o.we    = req_i.we;
  assign l2_req_o.idx   = l2_off >> 2;
  assign l2_req_o.wdata = req_i.wdata;

  assign cfg_valid_o     = valid_i && hit_cfg;
  assign cfg_req_o.we    = req_i.we;
  assign cfg_req_o.idx   = cfg_off >> 2;
  assign cfg_req_o.wdata = req_i.wdata;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q   <= 1'b0;
      sel_l2_q  <= 1'b0;
      sel_cfg_q <= 1'b0;
    end else begin
      valid_q   <= valid_i;
      sel_l2_q  <= l2_valid_o;
      sel_cfg_q <= cfg_valid_o;
    end
  end

  assign rsp_valid_o = valid_q;

  always_comb begin
    rsp_o = '0;
    if (sel_l2_q) begin
      rsp_o.rdata = l2_rdata_i;
    end else if (sel_cfg_q) begin
      rsp_o = cfg_rsp_i;
    end else begin
      rsp_o.err = valid_q;
    end
  end

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0({l2_valid_o, cfg_valid_o}))
    else $error("request routed to more than one target");

endmodule

//--- hdl/req_credit_buffer.sv
// Credit-based request buffer
// Circular FIFO on the host request port. The head is handed on in every
// cycle it holds an entry, and each pop returns one credit to the host.
`timescale 1ns/100ps

module req_credit_buffer #(
  parameter int unsigned Depth = 4
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   push_i,
  input  host_bus_pkg::host_req_t push_req_i,
  output logic                   pop_o,
  output host_bus_pkg::host_req_t pop_req_o,
  output logic                   credit_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  host_bus_pkg::host_req_t mem_q [Depth];

  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            empty;
  logic            full;

  assign empty = (count_q == '0);
  assign full  = (count_q == CntW'(Depth));

  // Downstream never stalls
  assign pop_o     = !empty;
  assign pop_req_o = mem_q[rd_ptr_q];
  assign credit_o  = pop_o;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_req_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_o) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CntW'(push_i) - CntW'(pop_o);
    end
  end

  // Host must hold a credit for every push
  assert property (@(posedge clk_i) disable iff (!arst_n_i) push_i |-> !full)
    else $error("request pushed into a full buffer");

endmodule

//--- hdl/host_bus_pkg.sv
// Host bus types
// Request and response payloads of the host port and of the
// target ports behind the address router
package host_bus_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // Request as issued by the host
  typedef struct packed {
    logic  we;
    addr_t addr;
    data_t wdata;
  } host_req_t;

  // One response per request, in order
  typedef struct packed {
    data_t rdata;
    logic  err;
  } host_rsp_t;

  // Request steered to a single target, word indexed
  typedef struct packed {
    logic  we;
    addr_t idx;
    data_t wdata;
  } tgt_req_t;

endpackage

//--- hdl/host_cfg_pkg.sv
// Host domain configuration
// Memory map of the host port and default sizing of the L2 scratchpad,
// the request buffer and the register block
package host_cfg_pkg;

  // Address windows
  localparam logic [31:0] L2BaseAddr  = 32'h1C00_0000;
  localparam logic [31:0] CfgBaseAddr = 32'h1A10_4000;

  // Register block size in 32-bit registers
  localparam int unsigned CfgNumRegs = 4;

  // Default sizing
  localparam int unsigned DefNbL2Banks   = 8;
  localparam int unsigned DefL2BankWords = 256;
  // Also the number of credits the host starts with
  localparam int unsigned DefBufferDepth = 4;

  // Byte offsets inside the register block
  localparam logic [31:0] CfgCacheStartOff = 32'h0;
  localparam logic [31:0] CfgCacheEndOff   = 32'h4;
  localparam logic [31:0] CfgSpmStartOff   = 32'h8;
  localparam logic [31:0] CfgDmaEvtCntOff  = 32'hC;

endpackage
